//--- common/exu_pkg.sv
`default_nettype none

package exu_pkg;

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [31:0]     inst_t;
  typedef logic [3:0]      reg_idx_t;
  typedef logic [3:0]      alu_op_t;
  typedef logic [11:0]     csr_addr_t;

  localparam alu_op_t ALU_ADD  = 4'd0;
  localparam alu_op_t ALU_SUB  = 4'd1;
  localparam alu_op_t ALU_XOR  = 4'd2;
  localparam alu_op_t ALU_OR   = 4'd3;
  localparam alu_op_t ALU_AND  = 4'd4;
  localparam alu_op_t ALU_SLL  = 4'd5;
  localparam alu_op_t ALU_SRL  = 4'd6;
  localparam alu_op_t ALU_SRA  = 4'd7;
  localparam alu_op_t ALU_SLT  = 4'd8;
  localparam alu_op_t ALU_SLTU = 4'd9;
  localparam alu_op_t ALU_SLE  = 4'd10;
  localparam alu_op_t ALU_SLEU = 4'd11;

  // machine CSRs kept by the stage
  localparam csr_addr_t CSR_MSTATUS = 12'h300;
  localparam csr_addr_t CSR_MTVEC   = 12'h305;
  localparam csr_addr_t CSR_MEPC    = 12'h341;
  localparam csr_addr_t CSR_MCAUSE  = 12'h342;

  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  localparam logic [2:0] F3_PRIV   = 3'd0;
  localparam logic [2:0] F3_CSRRW  = 3'd1;
  localparam logic [2:0] F3_CSRRS  = 3'd2;
  localparam logic [2:0] F3_CSRRC  = 3'd3;
  localparam logic [2:0] F3_CSRRWI = 3'd5;
  localparam logic [2:0] F3_CSRRSI = 3'd6;
  localparam logic [2:0] F3_CSRRCI = 3'd7;

  // imm field of a funct3 == 0 system instruction
  localparam logic [11:0] SYS_ECALL  = 12'h000;
  localparam logic [11:0] SYS_EBREAK = 12'h001;
  localparam logic [11:0] SYS_MRET   = 12'h302;

  localparam word_t CAUSE_ECALL_M = 32'd11;

endpackage

`default_nettype wire

//--- src/exu_alu.sv
`default_nettype none

module exu_alu
  import exu_pkg::*;
#(
  parameter int XLEN = exu_pkg::XLEN
) (
  input  logic [XLEN-1:0] src1_i,
  input  logic [XLEN-1:0] src2_i,
  input  alu_op_t         alu_op_i,
  output logic [XLEN-1:0] res_o
);

  localparam int SHAMT_W = $clog2(XLEN);

  logic [SHAMT_W-1:0] shamt;
  logic               lt_s;
  logic               lt_u;
  logic               eq;

  assign shamt = src2_i[SHAMT_W-1:0];
  assign lt_s  = $signed(src1_i) < $signed(src2_i);
  assign lt_u  = src1_i < src2_i;
  assign eq    = src1_i == src2_i;

  always_comb begin
    case (alu_op_i)
      ALU_ADD:  res_o = src1_i + src2_i;
      ALU_SUB:  res_o = src1_i - src2_i;
      ALU_XOR:  res_o = src1_i ^ src2_i;
      ALU_OR:   res_o = src1_i | src2_i;
      ALU_AND:  res_o = src1_i & src2_i;
      ALU_SLL:  res_o = src1_i << shamt;
      ALU_SRL:  res_o = src1_i >> shamt;
      ALU_SRA:  res_o = $signed(src1_i) >>> shamt;
      // compares give 0 or 1
      ALU_SLT:  res_o = {{(XLEN-1){1'b0}}, lt_s};
      ALU_SLTU: res_o = {{(XLEN-1){1'b0}}, lt_u};
      ALU_SLE:  res_o = {{(XLEN-1){1'b0}}, lt_s | eq};
      ALU_SLEU: res_o = {{(XLEN-1){1'b0}}, lt_u | eq};
      default:  res_o = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- csr/csr_unit.sv
`default_nettype none

module csr_unit
  import exu_pkg::*;
#(
  parameter int XLEN = exu_pkg::XLEN
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            retire_i,
  input  inst_t           inst_i,
  input  logic [XLEN-1:0] imm_i,
  input  logic [XLEN-1:0] src1_i,
  input  logic [XLEN-1:0] pc_i,
  output logic [XLEN-1:0] rdata_o,
  output logic [XLEN-1:0] mtvec_o,
  output logic [XLEN-1:0] mepc_o
);

  logic [XLEN-1:0] mstatus;
  logic [XLEN-1:0] mtvec;
  logic [XLEN-1:0] mepc;
  logic [XLEN-1:0] mcause;
  logic [XLEN-1:0] wdata;
  logic [2:0]      funct3;
  logic            is_sys;
  logic            is_priv;
  logic            is_csr;
  logic            is_ecall;
  logic            is_mret;
  logic            wen;
  csr_addr_t       addr;

  assign funct3   = inst_i[14:12];
  assign is_sys   = inst_i[6:0] == OP_SYSTEM;
  assign is_priv  = is_sys && funct3 == F3_PRIV;
  assign is_ecall = is_priv && imm_i[11:0] == SYS_ECALL;
  assign is_mret  = is_priv && imm_i[11:0] == SYS_MRET;
  assign is_csr   = is_sys && funct3 inside {F3_CSRRW, F3_CSRRS, F3_CSRRC,
                                             F3_CSRRWI, F3_CSRRSI, F3_CSRRCI};

  // ecall reports through mcause, mret rewrites mstatus
  assign addr = is_ecall ? CSR_MCAUSE :
                is_mret  ? CSR_MSTATUS : imm_i[11:0];

  always_comb begin
    case (addr)
      CSR_MSTATUS: rdata_o = mstatus;
      CSR_MTVEC:   rdata_o = mtvec;
      CSR_MEPC:    rdata_o = mepc;
      CSR_MCAUSE:  rdata_o = mcause;
      default:     rdata_o = '0;
    endcase
  end

  always_comb begin
    if (is_ecall) begin
      wdata = XLEN'(CAUSE_ECALL_M);
    end else if (is_mret) begin
      // MIE <= MPIE, MPIE <= 1
      wdata = {rdata_o[XLEN-1:8], 1'b1, rdata_o[6:4], rdata_o[7], rdata_o[2:0]};
    end else begin
      case (funct3)
        F3_CSRRS, F3_CSRRSI: wdata = rdata_o | src1_i;
        F3_CSRRC, F3_CSRRCI: wdata = rdata_o & ~src1_i;
        default:             wdata = src1_i;
      endcase
    end
  end

  // commit only on retire so a stalled output never writes twice
  assign wen = retire_i && (is_csr || is_ecall || is_mret);

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus <= '0;
      mtvec   <= '0;
      mepc    <= '0;
      mcause  <= '0;
    end else if (wen) begin
      case (addr)
        CSR_MSTATUS: mstatus <= wdata;
        CSR_MTVEC:   mtvec   <= wdata;
        CSR_MEPC:    mepc    <= wdata;
        CSR_MCAUSE:  mcause  <= wdata;
        default:     ;
      endcase
      if (is_ecall) begin
        mepc <= pc_i;
      end
    end
  end

  assign mtvec_o = mtvec;
  assign mepc_o  = mepc;

endmodule

`default_nettype wire

//--- src/exu_issue_ctrl.sv
`default_nettype none

module exu_issue_ctrl
  import exu_pkg::*;
#(
  parameter int XLEN = exu_pkg::XLEN
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            issue_valid_i,
  input  inst_t           inst_i,
  input  logic [XLEN-1:0] pc_i,
  input  logic [XLEN-1:0] op1_i,
  input  logic [XLEN-1:0] op2_i,
  input  logic [XLEN-1:0] imm_i,
  input  logic [XLEN-1:0] jbase_i,
  input  alu_op_t         alu_op_i,
  input  reg_idx_t        rd_i,
  input  logic            ren_i,
  input  logic            wen_i,
  input  logic            next_ready_i,
  input  logic            mem_rvalid_i,
  input  logic            mem_wready_i,
  input  logic [XLEN-1:0] mem_rdata_i,
  output logic            ready_o,
  output logic            valid_o,
  output logic            retire_o,
  output inst_t           inst_q_o,
  output logic [XLEN-1:0] pc_q_o,
  output logic [XLEN-1:0] src1_o,
  output logic [XLEN-1:0] src2_o,
  output logic [XLEN-1:0] imm_q_o,
  output logic [XLEN-1:0] target_q_o,
  output alu_op_t         alu_op_q_o,
  output reg_idx_t        rd_q_o,
  output logic            mem_req_o,
  output logic            mem_we_o,
  output logic [XLEN-1:0] mem_addr_o,
  output logic [XLEN-1:0] mem_rdata_q_o
);

  logic busy;
  logic alu_valid;
  logic mem_valid;
  logic mem_req;
  logic ren_q;
  logic wen_q;
  logic issue;
  logic mem_done;

  assign valid_o  = (ren_q | wen_q) ? mem_valid : alu_valid;
  assign retire_o = valid_o & next_ready_i;
  // accept when the bus is idle or done and the output slot frees up
  assign ready_o  = (!busy | mem_valid) & (!valid_o | next_ready_i);
  assign issue    = issue_valid_i & ready_o;
  assign mem_done = mem_req & ((ren_q & mem_rvalid_i) | (wen_q & mem_wready_i));

  assign mem_req_o = mem_req;
  assign mem_we_o  = wen_q;

  always_ff @(posedge clk) begin
    if (issue) begin
      inst_q_o   <= inst_i;
      pc_q_o     <= pc_i;
      src1_o     <= op1_i;
      src2_o     <= op2_i;
      imm_q_o    <= imm_i;
      target_q_o <= jbase_i + imm_i;
      alu_op_q_o <= alu_op_i;
      rd_q_o     <= rd_i;
      mem_addr_o <= op1_i + imm_i;
    end
    if (mem_done && ren_q) begin
      mem_rdata_q_o <= mem_rdata_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      alu_valid <= 1'b0;
      mem_valid <= 1'b0;
      busy      <= 1'b0;
      mem_req   <= 1'b0;
      ren_q     <= 1'b0;
      wen_q     <= 1'b0;
    end else begin
      if (retire_o) begin
        alu_valid <= 1'b0;
        mem_valid <= 1'b0;
        busy      <= 1'b0;
      end
      if (mem_done) begin
        mem_req   <= 1'b0;
        mem_valid <= 1'b1;
      end
      // a new issue at the retire edge overrides the clears above
      if (issue) begin
        alu_valid <= !(ren_i | wen_i);
        mem_valid <= 1'b0;
        busy      <= ren_i | wen_i;
        mem_req   <= ren_i | wen_i;
        ren_q     <= ren_i;
        wen_q     <= wen_i;
      end
    end
  end

endmodule

`default_nettype wire

//--- src/exu_result_sel.sv
`default_nettype none

module exu_result_sel
  import exu_pkg::*;
#(
  parameter int XLEN = exu_pkg::XLEN
) (
  input  inst_t           inst_i,
  input  alu_op_t         alu_op_i,
  input  reg_idx_t        rd_i,
  input  logic [XLEN-1:0] alu_res_i,
  input  logic [XLEN-1:0] csr_rdata_i,
  input  logic [XLEN-1:0] mem_rdata_i,
  input  logic [XLEN-1:0] target_i,
  input  logic [XLEN-1:0] mtvec_i,
  input  logic [XLEN-1:0] mepc_i,
  input  logic            valid_i,
  output logic [XLEN-1:0] rd_wdata_o,
  output logic [XLEN-1:0] npc_o,
  output logic            npc_take_o,
  output logic            ebreak_o
);

  logic [6:0]  opcode;
  logic [11:0] sys_imm;
  logic        is_sys;
  logic        is_priv;
  logic        is_ecall;
  logic        is_mret;
  logic        take;

  assign opcode   = inst_i[6:0];
  assign sys_imm  = inst_i[31:20];
  assign is_sys   = opcode == OP_SYSTEM;
  assign is_priv  = is_sys && inst_i[14:12] == F3_PRIV;
  assign is_ecall = is_priv && sys_imm == SYS_ECALL;
  assign is_mret  = is_priv && sys_imm == SYS_MRET;
  assign ebreak_o = is_priv && sys_imm == SYS_EBREAK;

  assign rd_wdata_o = (rd_i == '0)         ? '0 :
                      (opcode == OP_LOAD)  ? mem_rdata_i :
                      is_sys               ? csr_rdata_i : alu_res_i;

  always_comb begin
    case (opcode)
      // beq/bne use sub, the others a set-less compare
      OP_BRANCH:        take = (alu_op_i == ALU_SUB) ? ~|alu_res_i : |alu_res_i;
      OP_JAL, OP_JALR:  take = 1'b1;
      OP_SYSTEM:        take = is_ecall | is_mret;
      default:          take = 1'b0;
    endcase
  end

  assign npc_o      = is_ecall ? mtvec_i :
                      is_mret  ? mepc_i  : target_i;
  assign npc_take_o = take & valid_i;

endmodule

`default_nettype wire

//--- src/exu_top.sv
`default_nettype none

module exu_top
  import exu_pkg::*;
#(
  parameter int XLEN = exu_pkg::XLEN
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            issue_valid_i,
  input  inst_t           inst_i,
  input  logic [XLEN-1:0] pc_i,
  input  logic [XLEN-1:0] op1_i,
  input  logic [XLEN-1:0] op2_i,
  input  logic [XLEN-1:0] imm_i,
  input  logic [XLEN-1:0] jbase_i,
  input  alu_op_t         alu_op_i,
  input  reg_idx_t        rd_i,
  input  logic            ren_i,
  input  logic            wen_i,
  input  logic            next_ready_i,
  input  logic [XLEN-1:0] mem_rdata_i,
  input  logic            mem_rvalid_i,
  input  logic            mem_wready_i,
  output logic            ready_o,
  output logic            valid_o,
  output reg_idx_t        rd_o,
  output logic [XLEN-1:0] rd_wdata_o,
  output logic [XLEN-1:0] npc_o,
  output logic            npc_take_o,
  output logic            ebreak_o,
  output logic [XLEN-1:0] pc_o,
  output logic            mem_req_o,
  output logic            mem_we_o,
  output logic [XLEN-1:0] mem_addr_o,
  output logic [XLEN-1:0] mem_wdata_o
);

  logic            retire;
  inst_t           inst_q;
  logic [XLEN-1:0] src1;
  logic [XLEN-1:0] src2;
  logic [XLEN-1:0] imm_q;
  logic [XLEN-1:0] target_q;
  alu_op_t         alu_op_q;
  logic [XLEN-1:0] mem_rdata_q;
  logic [XLEN-1:0] alu_res;
  logic [XLEN-1:0] csr_rdata;
  logic [XLEN-1:0] mtvec;
  logic [XLEN-1:0] mepc;

  // store data is the latched second operand
  assign mem_wdata_o = src2;

  exu_issue_ctrl #(
    .XLEN(XLEN)
  ) u_issue (
    .clk          (clk),
    .rst          (rst),
    .issue_valid_i(issue_valid_i),
    .inst_i       (inst_i),
    .pc_i         (pc_i),
    .op1_i        (op1_i),
    .op2_i        (op2_i),
    .imm_i        (imm_i),
    .jbase_i      (jbase_i),
    .alu_op_i     (alu_op_i),
    .rd_i         (rd_i),
    .ren_i        (ren_i),
    .wen_i        (wen_i),
    .next_ready_i (next_ready_i),
    .mem_rvalid_i (mem_rvalid_i),
    .mem_wready_i (mem_wready_i),
    .mem_rdata_i  (mem_rdata_i),
    .ready_o      (ready_o),
    .valid_o      (valid_o),
    .retire_o     (retire),
    .inst_q_o     (inst_q),
    .pc_q_o       (pc_o),
    .src1_o       (src1),
    .src2_o       (src2),
    .imm_q_o      (imm_q),
    .target_q_o   (target_q),
    .alu_op_q_o   (alu_op_q),
    .rd_q_o       (rd_o),
    .mem_req_o    (mem_req_o),
    .mem_we_o     (mem_we_o),
    .mem_addr_o   (mem_addr_o),
    .mem_rdata_q_o(mem_rdata_q)
  );

  exu_alu #(
    .XLEN(XLEN)
  ) u_alu (
    .src1_i  (src1),
    .src2_i  (src2),
    .alu_op_i(alu_op_q),
    .res_o   (alu_res)
  );

  csr_unit #(
    .XLEN(XLEN)
  ) u_csr (
    .clk     (clk),
    .rst     (rst),
    .retire_i(retire),
    .inst_i  (inst_q),
    .imm_i   (imm_q),
    .src1_i  (src1),
    .pc_i    (pc_o),
    .rdata_o (csr_rdata),
    .mtvec_o (mtvec),
    .mepc_o  (mepc)
  );

  exu_result_sel #(
    .XLEN(XLEN)
  ) u_sel (
    .inst_i     (inst_q),
    .alu_op_i   (alu_op_q),
    .rd_i       (rd_o),
    .alu_res_i  (alu_res),
    .csr_rdata_i(csr_rdata),
    .mem_rdata_i(mem_rdata_q),
    .target_i   (target_q),
    .mtvec_i    (mtvec),
    .mepc_i     (mepc),
    .valid_i    (valid_o),
    .rd_wdata_o (rd_wdata_o),
    .npc_o      (npc_o),
    .npc_take_o (npc_take_o),
    .ebreak_o   (ebreak_o)
  );

endmodule

`default_nettype wire

//--- test/exu_checker.sv
`default_nettype none

module exu_checker
  import exu_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     issue_valid_i,
  input  inst_t    inst_i,
  input  word_t    pc_i,
  input  word_t    op1_i,
  input  word_t    op2_i,
  input  word_t    imm_i,
  input  word_t    jbase_i,
  input  alu_op_t  alu_op_i,
  input  reg_idx_t rd_i,
  input  logic     next_ready_i,
  input  logic     mem_rvalid_i,
  input  logic     mem_wready_i,
  input  logic     dut_ready_i,
  input  logic     dut_valid_i,
  input  reg_idx_t dut_rd_i,
  input  word_t    dut_wdata_i,
  input  word_t    dut_npc_i,
  input  logic     dut_take_i,
  input  logic     dut_ebreak_i,
  input  word_t    dut_pc_i,
  input  logic     mem_req_i,
  input  logic     mem_we_i,
  input  word_t    mem_addr_i,
  input  word_t    mem_wdata_i,
  output int       err_count_o,
  output int       retire_count_o
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam word_t RDATA_MASK = 32'h5a5a_a5a5;

  typedef struct packed {
    inst_t    inst;
    word_t    pc;
    word_t    op1;
    word_t    op2;
    word_t    imm;
    word_t    jbase;
    alu_op_t  alu_op;
    reg_idx_t rd;
  } rec_t;

  typedef struct packed {
    word_t wdata;
    word_t npc;
    logic  take;
    logic  ebreak;
  } exp_t;

  rec_t  pending[$];
  word_t mstatus_m;
  word_t mtvec_m;
  word_t mepc_m;
  word_t mcause_m;
  int    errs = 0;
  int    retires = 0;
  logic  rst_q = 1'b0;
  logic  strobe_seen = 1'b0;

  assign err_count_o    = errs;
  assign retire_count_o = retires;

  function automatic word_t alu_model(alu_op_t op, word_t a, word_t b);
    case (op)
      ALU_ADD:  return a + b;
      ALU_SUB:  return a - b;
      ALU_XOR:  return a ^ b;
      ALU_OR:   return a | b;
      ALU_AND:  return a & b;
      ALU_SLL:  return a << b[4:0];
      ALU_SRL:  return a >> b[4:0];
      ALU_SRA:  return word_t'($signed(a) >>> b[4:0]);
      ALU_SLT:  return word_t'($signed(a) < $signed(b));
      ALU_SLTU: return word_t'(a < b);
      ALU_SLE:  return word_t'($signed(a) <= $signed(b));
      ALU_SLEU: return word_t'(a <= b);
      default:  return '0;
    endcase
  endfunction

  function automatic word_t csr_model_read(logic [11:0] addr);
    case (addr)
      CSR_MSTATUS: return mstatus_m;
      CSR_MTVEC:   return mtvec_m;
      CSR_MEPC:    return mepc_m;
      CSR_MCAUSE:  return mcause_m;
      default:     return '0;
    endcase
  endfunction

  // expected stage outputs for one instruction from the current CSR copy
  function automatic exp_t expected(rec_t r);
    exp_t  e;
    logic  is_sys;
    logic  priv;
    logic  is_ecall;
    logic  is_mret;
    word_t res;
    is_sys   = r.inst[6:0] == OP_SYSTEM;
    priv     = is_sys && r.inst[14:12] == F3_PRIV;
    is_ecall = priv && r.imm[11:0] == SYS_ECALL;
    is_mret  = priv && r.imm[11:0] == SYS_MRET;
    res      = alu_model(r.alu_op, r.op1, r.op2);
    e.ebreak = priv && r.imm[11:0] == SYS_EBREAK;
    e.npc    = is_ecall ? mtvec_m : (is_mret ? mepc_m : r.jbase + r.imm);
    case (r.inst[6:0])
      OP_BRANCH:       e.take = (r.alu_op == ALU_SUB) ? (res == 0) : (res != 0);
      OP_JAL, OP_JALR: e.take = 1'b1;
      default:         e.take = is_ecall || is_mret;
    endcase
    if (r.rd == 0) begin
      e.wdata = '0;
    end else if (r.inst[6:0] == OP_LOAD) begin
      e.wdata = (r.op1 + r.imm) ^ RDATA_MASK;
    end else if (is_sys) begin
      e.wdata = csr_model_read(is_ecall ? CSR_MCAUSE : (is_mret ? CSR_MSTATUS : r.imm[11:0]));
    end else begin
      e.wdata = res;
    end
    return e;
  endfunction

  task automatic csr_model_retire(rec_t r);
    logic [2:0]  f3;
    logic [11:0] addr;
    word_t       nv;
    f3   = r.inst[14:12];
    addr = r.imm[11:0];
    if (r.inst[6:0] != OP_SYSTEM) begin
      return;
    end
    if (f3 == F3_PRIV) begin
      if (addr == SYS_ECALL) begin
        mcause_m = CAUSE_ECALL_M;
        mepc_m   = r.pc;
      end else if (addr == SYS_MRET) begin
        // MPIE into MIE, MPIE set
        mstatus_m[3] = mstatus_m[7];
        mstatus_m[7] = 1'b1;
      end
      return;
    end
    case (f3)
      F3_CSRRS, F3_CSRRSI: nv = csr_model_read(addr) | r.op1;
      F3_CSRRC, F3_CSRRCI: nv = csr_model_read(addr) & ~r.op1;
      default:             nv = r.op1;
    endcase
    case (addr)
      CSR_MSTATUS: mstatus_m = nv;
      CSR_MTVEC:   mtvec_m   = nv;
      CSR_MEPC:    mepc_m    = nv;
      CSR_MCAUSE:  mcause_m  = nv;
      default:     ;
    endcase
  endtask

  task automatic check_word(string what, word_t got, word_t want);
    if (got !== want) begin
      $display("mismatch at %0d ns: %s is %h, expected %h", $time, what, got, want);
      errs++;
    end
  endtask

  always @(posedge clk) begin : compare
    rec_t r;
    exp_t e;
    if (rst_q && (dut_valid_i !== 1'b0 || mem_req_i !== 1'b0 || dut_ready_i !== 1'b1)) begin
      $display("stage outputs were not idle after reset at %0d ns", $time);
      errs++;
    end
    if (rst) begin
      pending.delete();
      mstatus_m   = '0;
      mtvec_m     = '0;
      mepc_m      = '0;
      mcause_m    = '0;
      retires     = 0;
      strobe_seen = 1'b0;
    end else begin
      if (strobe_seen && (mem_req_i || !dut_valid_i)) begin
        $display("mismatch at %0d ns: mem_req_o %b valid_o %b after bus strobe",
                 $time, mem_req_i, dut_valid_i);
        errs++;
      end
      strobe_seen = 1'b0;
      if (!dut_valid_i && dut_take_i !== 1'b0) begin
        $display("mismatch at %0d ns: npc_take_o is high while valid_o is low", $time);
        errs++;
      end
      if (mem_req_i && (mem_we_i ? mem_wready_i : mem_rvalid_i)) begin
        strobe_seen = 1'b1;
        if (pending.size() == 0) begin
          $display("bus request seen with no instruction in flight at %0d ns", $time);
          errs++;
        end else begin
          r = pending[0];
          check_word("mem_we_o", word_t'(mem_we_i), word_t'(r.inst[6:0] == OP_STORE));
          check_word("mem_addr_o", mem_addr_i, r.op1 + r.imm);
          if (mem_we_i) begin
            check_word("mem_wdata_o", mem_wdata_i, r.op2);
          end
        end
      end
      if (dut_valid_i && next_ready_i) begin
        if (pending.size() == 0) begin
          $display("instruction retired with none in flight at %0d ns", $time);
          errs++;
        end else begin
          r = pending.pop_front();
          e = expected(r);
          check_word("rd_o", word_t'(dut_rd_i), word_t'(r.rd));
          check_word("pc_o", dut_pc_i, r.pc);
          check_word("rd_wdata_o", dut_wdata_i, e.wdata);
          check_word("npc_o", dut_npc_i, e.npc);
          check_word("npc_take_o", word_t'(dut_take_i), word_t'(e.take));
          check_word("ebreak_o", word_t'(dut_ebreak_i), word_t'(e.ebreak));
          csr_model_retire(r);
          retires++;
        end
      end
      if (issue_valid_i && dut_ready_i) begin
        if (pending.size() != 0) begin
          $display("instruction accepted before the previous one retired at %0d ns", $time);
          errs++;
        end
        pending.push_back({inst_i, pc_i, op1_i, op2_i, imm_i, jbase_i, alu_op_i, rd_i});
      end
    end
    rst_q = rst;
  end

endmodule

`default_nettype wire

//--- test/exu_tb.sv
`default_nettype none

module exu_tb
  import exu_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int         CLK_PERIOD = 40;
  localparam int         N_INST     = 400;
  localparam int         WAIT_LIMIT = 200;
  localparam logic [31:0] SEED      = 32'hb8ad9bf3;
  localparam word_t      RDATA_MASK = 32'h5a5a_a5a5;
  localparam logic [6:0] OP_ALU     = 7'b0110011;

  logic     clk;
  logic     rst;
  logic     issue_valid_i;
  inst_t    inst_i;
  word_t    pc_i;
  word_t    op1_i;
  word_t    op2_i;
  word_t    imm_i;
  word_t    jbase_i;
  alu_op_t  alu_op_i;
  reg_idx_t rd_i;
  logic     ren_i;
  logic     wen_i;
  logic     next_ready_i;
  word_t    mem_rdata_i;
  logic     mem_rvalid_i;
  logic     mem_wready_i;
  logic     ready_o;
  logic     valid_o;
  reg_idx_t rd_o;
  word_t    rd_wdata_o;
  word_t    npc_o;
  logic     npc_take_o;
  logic     ebreak_o;
  word_t    pc_o;
  logic     mem_req_o;
  logic     mem_we_o;
  word_t    mem_addr_o;
  word_t    mem_wdata_o;

  int   err_count;
  int   retire_count;
  int   issued;
  int   waited;
  logic timed_out;

  exu_top UUT (.*);

  exu_checker u_checker (
    .clk           (clk),
    .rst           (rst),
    .issue_valid_i (issue_valid_i),
    .inst_i        (inst_i),
    .pc_i          (pc_i),
    .op1_i         (op1_i),
    .op2_i         (op2_i),
    .imm_i         (imm_i),
    .jbase_i       (jbase_i),
    .alu_op_i      (alu_op_i),
    .rd_i          (rd_i),
    .next_ready_i  (next_ready_i),
    .mem_rvalid_i  (mem_rvalid_i),
    .mem_wready_i  (mem_wready_i),
    .dut_ready_i   (ready_o),
    .dut_valid_i   (valid_o),
    .dut_rd_i      (rd_o),
    .dut_wdata_i   (rd_wdata_o),
    .dut_npc_i     (npc_o),
    .dut_take_i    (npc_take_o),
    .dut_ebreak_i  (ebreak_o),
    .dut_pc_i      (pc_o),
    .mem_req_i     (mem_req_o),
    .mem_we_i      (mem_we_o),
    .mem_addr_i    (mem_addr_o),
    .mem_wdata_i   (mem_wdata_o),
    .err_count_o   (err_count),
    .retire_count_o(retire_count)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // answers a request after 0 to 4 cycles with a one-cycle strobe
  task automatic respond_memory();
    int   delay;
    logic done;
    delay = $urandom_range(4);
    done  = 1'b0;
    forever begin
      @(negedge clk);
      mem_rvalid_i = 1'b0;
      mem_wready_i = 1'b0;
      if (!mem_req_o) begin
        done  = 1'b0;
        delay = $urandom_range(4);
      end else if (!done) begin
        if (delay == 0) begin
          mem_rdata_i  = mem_addr_o ^ RDATA_MASK;
          mem_rvalid_i = !mem_we_o;
          mem_wready_i = mem_we_o;
          done         = 1'b1;
        end else begin
          delay--;
        end
      end
    end
  endtask

  task automatic drive_back_pressure();
    forever begin
      @(negedge clk);
      next_ready_i = ($urandom_range(3) != 0);
    end
  endtask

  task automatic drive_random_inst();
    int          kind;
    int          k;
    logic [2:0]  f3;
    logic [6:0]  opcode;
    kind     = $urandom_range(11);
    opcode   = OP_ALU;
    f3       = 3'd0;
    op1_i    = $urandom();
    op2_i    = $urandom();
    imm_i    = word_t'($urandom_range(4095)) & ~word_t'(1);
    jbase_i  = pc_i;
    alu_op_i = ALU_ADD;
    rd_i     = reg_idx_t'($urandom_range(15));
    ren_i    = 1'b0;
    wen_i    = 1'b0;
    case (kind)
      0, 1: begin
        alu_op_i = alu_op_t'($urandom_range(11));
      end
      2, 3: begin
        opcode = OP_BRANCH;
        k      = $urandom_range(4);
        // sub or one of the four set compares
        alu_op_i = (k == 0) ? ALU_SUB : alu_op_t'(7 + k);
        if ($urandom_range(1) == 0) begin
          op2_i = op1_i;
        end
      end
      4, 5: begin
        opcode = (kind == 4) ? OP_JAL : OP_JALR;
        op1_i  = pc_i;
        op2_i  = 32'd4;
        if (kind == 5) begin
          jbase_i = $urandom();
        end
      end
      6, 7: begin
        opcode = OP_SYSTEM;
        f3     = 3'($urandom_range(2) + 1);
        if ($urandom_range(1) == 0) begin
          f3    = f3 + 3'd4;
          op1_i = word_t'($urandom_range(31));
        end
        case ($urandom_range(4))
          0:       imm_i = word_t'(CSR_MSTATUS);
          1:       imm_i = word_t'(CSR_MTVEC);
          2:       imm_i = word_t'(CSR_MEPC);
          3:       imm_i = word_t'(CSR_MCAUSE);
          default: imm_i = 32'h7c0;
        endcase
      end
      8: begin
        opcode = OP_SYSTEM;
        case ($urandom_range(2))
          0:       imm_i = word_t'(SYS_ECALL);
          1:       imm_i = word_t'(SYS_MRET);
          default: imm_i = word_t'(SYS_EBREAK);
        endcase
      end
      default: begin
        opcode = (kind == 9) ? OP_STORE : OP_LOAD;
        op1_i  = $urandom() & ~word_t'(3);
        imm_i  = word_t'($urandom_range(255)) << 2;
        ren_i  = (opcode == OP_LOAD);
        wen_i  = (opcode == OP_STORE);
      end
    endcase
    inst_i        = {imm_i[11:0], 5'd0, f3, 1'b0, rd_i, opcode};
    issue_valid_i = 1'b1;
  endtask

  task automatic wait_accept();
    int   cnt;
    logic taken;
    cnt   = 0;
    taken = 1'b0;
    while (!taken && cnt < WAIT_LIMIT) begin
      @(posedge clk);
      taken = ready_o;
      @(negedge clk);
      cnt++;
    end
    issue_valid_i = 1'b0;
    if (taken) begin
      issued++;
      pc_i = pc_i + 32'd4;
    end else begin
      $display("timeout: ready_o stayed low for %0d cycles", WAIT_LIMIT);
      timed_out = 1'b1;
    end
  endtask

  initial begin
    void'($urandom(SEED));
    rst           = 1'b1;
    issue_valid_i = 1'b0;
    inst_i        = '0;
    pc_i          = 32'h0000_1000;
    op1_i         = '0;
    op2_i         = '0;
    imm_i         = '0;
    jbase_i       = '0;
    alu_op_i      = ALU_ADD;
    rd_i          = '0;
    ren_i         = 1'b0;
    wen_i         = 1'b0;
    next_ready_i  = 1'b1;
    mem_rdata_i   = '0;
    mem_rvalid_i  = 1'b0;
    mem_wready_i  = 1'b0;
    issued        = 0;
    timed_out     = 1'b0;
    fork
      respond_memory();
      drive_back_pressure();
    join_none
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    while (issued < N_INST && !timed_out) begin
      drive_random_inst();
      wait_accept();
      repeat ($urandom_range(3) == 0 ? $urandom_range(1, 2) : 0) @(negedge clk);
    end

    // let the last instruction drain
    waited = 0;
    while (!timed_out && retire_count != issued && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (!timed_out && retire_count != issued) begin
      $display("timeout: only %0d of %0d instructions retired", retire_count, issued);
      timed_out = 1'b1;
    end

    $display("done: %0d errors, %0d timeouts, %0d of %0d instructions retired",
             err_count, timed_out, retire_count, issued);
    if (err_count == 0 && !timed_out) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
common/exu_pkg.sv
src/exu_alu.sv
csr/csr_unit.sv
src/exu_issue_ctrl.sv
src/exu_result_sel.sv
src/exu_top.sv
test/exu_checker.sv
test/exu_tb.sv
